// File: hdl/bip_pkg.sv
package bip_pkg;

    //////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////

    // Opcode field width, upper bits of the instruction
    localparam int NB_OPCODE = 5;

    // Opcodes
    // Codes 8 to 31 are undefined and run as no-op
    typedef enum logic [NB_OPCODE-1:0] {
        OP_HLT  = 5'd0,     // Halt the run
        OP_STO  = 5'd1,     // Mem[operand] <= acc
        OP_LD   = 5'd2,     // Acc <= mem[operand]
        OP_LDI  = 5'd3,     // Acc <= ext(operand)
        OP_ADD  = 5'd4,     // Acc <= acc + mem[operand]
        OP_ADDI = 5'd5,     // Acc <= acc + ext(operand)
        OP_SUB  = 5'd6,     // Acc <= acc - mem[operand]
        OP_SUBI = 5'd7      // Acc <= acc - ext(operand)
    } opcode_t;

    //////////////////////////////////////////////////
    // Datapath controls
    //////////////////////////////////////////////////

    // Accumulator next-value source
    typedef enum logic [1:0] {
        SEL_A_MEM = 2'b00,
        SEL_A_IMM = 2'b01,
        SEL_A_ALU = 2'b10
    } sel_a_t;

    // ALU second operand source
    typedef enum logic {
        SEL_B_MEM = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_t;

    // Add/subtract select
    typedef enum logic {
        ALU_SUB = 1'b0,
        ALU_ADD = 1'b1
    } alu_op_t;

endpackage

// File: hdl/bip_datapath.sv
module bip_datapath #(
    parameter int NB_DATA    = 16,
    parameter int NB_OPERAND = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // Controls from the decoder
    input  bip_pkg::sel_a_t       i_sel_a,
    input  bip_pkg::sel_b_t       i_sel_b,
    input  logic                  i_wr_acc,
    input  bip_pkg::alu_op_t      i_alu_op,
    // Instruction operand
    input  logic [NB_OPERAND-1:0] i_operand,
    // Data memory read data
    input  logic [NB_DATA-1:0]    i_mem_rdata,
    // Accumulator, also the memory write data
    output logic [NB_DATA-1:0]    o_acc
);

    // Sign bits added on top of the operand
    localparam int NB_EXT = NB_DATA - NB_OPERAND;

    logic [NB_DATA-1:0] operand_ext;
    logic [NB_DATA-1:0] mux_a;
    logic [NB_DATA-1:0] mux_b;
    logic [NB_DATA-1:0] alu_out;
    logic [NB_DATA-1:0] acc;

    //////////////////////////////////////////////////
    // Operand extension and selectors
    //////////////////////////////////////////////////

    // Replicate operand MSB into the upper bits
    assign operand_ext = {{NB_EXT{i_operand[NB_OPERAND-1]}}, i_operand};

    // B input of the ALU
    always_comb begin
        case (i_sel_b)
            bip_pkg::SEL_B_IMM: mux_b = operand_ext;
            default:            mux_b = i_mem_rdata;
        endcase
    end

    // Add or subtract, wraps at NB_DATA bits
    always_comb begin
        case (i_alu_op)
            bip_pkg::ALU_ADD: alu_out = acc + mux_b;
            default:          alu_out = acc - mux_b;
        endcase
    end

    // Next accumulator value
    always_comb begin
        case (i_sel_a)
            bip_pkg::SEL_A_MEM: mux_a = i_mem_rdata;
            bip_pkg::SEL_A_IMM: mux_a = operand_ext;
            bip_pkg::SEL_A_ALU: mux_a = alu_out;
            default:            mux_a = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Accumulator
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            acc <= '0;
        end else if (i_wr_acc) begin
            acc <= mux_a;
        end
    end

    assign o_acc = acc;

endmodule

// File: hdl/bip_control.sv
module bip_control #(
    parameter int NB_OPERAND = 11,
    parameter int NB_PC      = 6
) (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    // Run handshake
    input  logic                                     i_req,
    // Fetched instruction, held by the program memory read register
    input  logic [bip_pkg::NB_OPCODE+NB_OPERAND-1:0] i_instr,
    output logic                                     o_ack,
    // Fetch address
    output logic [NB_PC-1:0]                         o_pc,
    // Operand, data address and immediate
    output logic [NB_OPERAND-1:0]                    o_operand,
    // Datapath and memory controls, live in EXEC only
    output bip_pkg::sel_a_t                          o_sel_a,
    output bip_pkg::sel_b_t                          o_sel_b,
    output logic                                     o_wr_acc,
    output bip_pkg::alu_op_t                         o_alu_op,
    output logic                                     o_mem_we
);

    localparam int NB_INSTR = bip_pkg::NB_OPCODE + NB_OPERAND;

    // Run sequencer states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXEC,
        DONE,
        ACK
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [NB_PC-1:0] pc;
    bip_pkg::opcode_t opcode;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    // Undefined codes fall to the decode default
    assign opcode    = bip_pkg::opcode_t'(i_instr[NB_INSTR-1:NB_OPERAND]);
    assign o_operand = i_instr[NB_OPERAND-1:0];

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            // Wait for a run request
            IDLE:    if (i_req) state_next = FETCH;
            // Program memory registers the word at PC
            FETCH:   state_next = EXEC;
            // Halt ends the run, anything else fetches again
            EXEC: begin
                if (opcode == bip_pkg::OP_HLT) begin
                    state_next = DONE;
                end else begin
                    state_next = FETCH;
                end
            end
            // One cycle before acknowledge goes high
            DONE:    state_next = ACK;
            // Results frozen until the host drops request
            ACK:     if (!i_req) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            state <= state_next;
            // Every run starts at address 0
            if (state == IDLE && i_req) begin
                pc <= '0;
            end else if (state == EXEC && opcode != bip_pkg::OP_HLT) begin
                // Wraps past the top address
                pc <= pc + 1'b1;
            end
        end
    end

    assign o_pc  = pc;
    assign o_ack = (state == ACK);

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    always_comb begin
        // Defaults write nothing
        o_sel_a  = bip_pkg::SEL_A_ALU;
        o_sel_b  = bip_pkg::SEL_B_MEM;
        o_alu_op = bip_pkg::ALU_ADD;
        o_wr_acc = 1'b0;
        o_mem_we = 1'b0;
        if (state == EXEC) begin
            case (opcode)
                bip_pkg::OP_STO:  o_mem_we = 1'b1;
                bip_pkg::OP_LD: begin
                    o_sel_a  = bip_pkg::SEL_A_MEM;
                    o_wr_acc = 1'b1;
                end
                bip_pkg::OP_LDI: begin
                    o_sel_a  = bip_pkg::SEL_A_IMM;
                    o_wr_acc = 1'b1;
                end
                bip_pkg::OP_ADD:  o_wr_acc = 1'b1;
                bip_pkg::OP_ADDI: begin
                    o_sel_b  = bip_pkg::SEL_B_IMM;
                    o_wr_acc = 1'b1;
                end
                bip_pkg::OP_SUB: begin
                    o_alu_op = bip_pkg::ALU_SUB;
                    o_wr_acc = 1'b1;
                end
                bip_pkg::OP_SUBI: begin
                    o_sel_b  = bip_pkg::SEL_B_IMM;
                    o_alu_op = bip_pkg::ALU_SUB;
                    o_wr_acc = 1'b1;
                end
                // Halt and undefined codes
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/bip_program_mem.sv
module bip_program_mem #(
    parameter int NB_PC = 6
) (
    input  logic             i_clk,
    // Host load port
    input  logic             i_we,
    input  logic [NB_PC-1:0] i_waddr,
    input  logic [15:0]      i_wdata,
    // Fetch port
    input  logic [NB_PC-1:0] i_raddr,
    output logic [15:0]      o_rdata
);

    // Number of instruction words
    localparam int DEPTH = 2 ** NB_PC;

    logic [15:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // Host write
    //////////////////////////////////////////////////

    // Loaded only while the processor is idle
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Fetch read
    //////////////////////////////////////////////////

    // Addressed in FETCH
    // Output holds the instruction through EXEC
    always_ff @(posedge i_clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: hdl/bip_data_mem.sv
module bip_data_mem #(
    parameter int NB_DATA    = 16,
    parameter int NB_OPERAND = 11
) (
    input  logic                  i_clk,
    // Processor port
    input  logic                  i_we,
    input  logic [NB_OPERAND-1:0] i_addr,
    input  logic [NB_DATA-1:0]    i_wdata,
    // Host read address
    input  logic [NB_OPERAND-1:0] i_host_addr,
    // Processor read data
    output logic [NB_DATA-1:0]    o_rdata,
    // Host read data
    output logic [NB_DATA-1:0]    o_host_rdata
);

    // One word per operand address
    localparam int DEPTH = 2 ** NB_OPERAND;

    logic [NB_DATA-1:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // Processor port
    //////////////////////////////////////////////////

    // Store lands on the closing edge of EXEC
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Combinational read
    // Loads and arithmetic see the word within EXEC
    assign o_rdata = mem[i_addr];

    //////////////////////////////////////////////////
    // Host port
    //////////////////////////////////////////////////

    // Independent read, meaningful once acknowledge is high
    assign o_host_rdata = mem[i_host_addr];

endmodule

// File: hdl/bip_top.sv
module bip_top #(
    parameter int NB_DATA    = 16,
    parameter int NB_OPERAND = 11,
    parameter int NB_PC      = 6
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // Program load, idle only
    input  logic                  i_prog_we,
    input  logic [NB_PC-1:0]      i_prog_addr,
    input  logic [15:0]           i_prog_data,
    // Four-phase run handshake
    input  logic                  i_req,
    output logic                  o_ack,
    // Results
    input  logic [NB_OPERAND-1:0] i_rd_addr,
    output logic [NB_DATA-1:0]    o_acc,
    output logic [NB_DATA-1:0]    o_rd_data
);

    // Fetch path
    logic [NB_PC-1:0]                         pc;
    logic [bip_pkg::NB_OPCODE+NB_OPERAND-1:0] instr;

    // Decoded controls
    logic [NB_OPERAND-1:0] operand;
    bip_pkg::sel_a_t       sel_a;
    bip_pkg::sel_b_t       sel_b;
    bip_pkg::alu_op_t      alu_op;
    logic                  wr_acc;
    logic                  mem_we;

    // Data memory read into the datapath
    logic [NB_DATA-1:0] mem_rdata;

    //////////////////////////////////////////////////
    // Control and fetch
    //////////////////////////////////////////////////

    bip_control #(
        .NB_OPERAND (NB_OPERAND),
        .NB_PC      (NB_PC)
    ) i_bip_control (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_req     (i_req),
        .i_instr   (instr),
        .o_ack     (o_ack),
        .o_pc      (pc),
        .o_operand (operand),
        .o_sel_a   (sel_a),
        .o_sel_b   (sel_b),
        .o_wr_acc  (wr_acc),
        .o_alu_op  (alu_op),
        .o_mem_we  (mem_we)
    );

    bip_program_mem #(
        .NB_PC (NB_PC)
    ) i_bip_program_mem (
        .i_clk   (i_clk),
        .i_we    (i_prog_we),
        .i_waddr (i_prog_addr),
        .i_wdata (i_prog_data),
        .i_raddr (pc),
        .o_rdata (instr)
    );

    //////////////////////////////////////////////////
    // Datapath and data memory
    //////////////////////////////////////////////////

    // Accumulator doubles as store data and host result
    bip_datapath #(
        .NB_DATA    (NB_DATA),
        .NB_OPERAND (NB_OPERAND)
    ) i_bip_datapath (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sel_a     (sel_a),
        .i_sel_b     (sel_b),
        .i_wr_acc    (wr_acc),
        .i_alu_op    (alu_op),
        .i_operand   (operand),
        .i_mem_rdata (mem_rdata),
        .o_acc       (o_acc)
    );

    bip_data_mem #(
        .NB_DATA    (NB_DATA),
        .NB_OPERAND (NB_OPERAND)
    ) i_bip_data_mem (
        .i_clk        (i_clk),
        .i_we         (mem_we),
        .i_addr       (operand),
        .i_wdata      (o_acc),
        .i_host_addr  (i_rd_addr),
        .o_rdata      (mem_rdata),
        .o_host_rdata (o_rd_data)
    );

endmodule

// File: verif/bip_chk.sv
module bip_chk (
    input logic i_clk,
    input logic i_rst,
    input logic i_req,
    input logic i_ack,
    input logic i_wr_acc,
    input logic i_mem_we
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Low through reset and the cycle after
    ack_reset_low: assert property (@(posedge i_clk) !i_rst |=> !i_ack)
        else $error("Acknowledge high during or right after reset");

    ack_rise_req: assert property (@(posedge i_clk) disable iff (!i_rst)
        $rose(i_ack) |-> i_req)
        else $error("Acknowledge rose without a request");

    // Back-pressure keeps acknowledge up
    ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_ack && i_req |=> i_ack)
        else $error("Acknowledge dropped while request still high");

    ack_fall: assert property (@(posedge i_clk) disable iff (!i_rst)
        $fell(i_ack) |-> !$past(i_req))
        else $error("Acknowledge fell before request fell");

    //////////////////////////////////////////////////
    // Idle behaviour
    //////////////////////////////////////////////////

    // Writes only inside a running request
    write_window: assert property (@(posedge i_clk) disable iff (!i_rst)
        (i_wr_acc || i_mem_we) |-> (i_req && !i_ack))
        else $error("Accumulator or memory written outside a run");

endmodule

bind bip_top bip_chk i_bip_chk (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_req    (i_req),
    .i_ack    (o_ack),
    .i_wr_acc (wr_acc),
    .i_mem_we (mem_we)
);

// File: verif/bip_tb.sv
module bip_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB_DATA      = 16;
    localparam int NB_OPERAND   = 11;
    localparam int NB_PC        = 6;
    localparam int PROG_WORDS   = 12;
    localparam int N_FIXED      = 7;
    localparam int N_TESTS      = 11;
    localparam int RESET_CYCLES = 8;
    // Hold, request drop and read-back per entry
    localparam int OVERHEAD     = 40;
    localparam int TIMEOUT      = RESET_CYCLES
        + 2 * N_TESTS * (2 * PROG_WORDS + PROG_WORDS + 1 + OVERHEAD);

    // Opcode fields for the program table
    localparam logic [4:0]  LDI   = bip_pkg::OP_LDI;
    localparam logic [4:0]  LD    = bip_pkg::OP_LD;
    localparam logic [4:0]  STO   = bip_pkg::OP_STO;
    localparam logic [4:0]  ADD   = bip_pkg::OP_ADD;
    localparam logic [4:0]  ADDI  = bip_pkg::OP_ADDI;
    localparam logic [4:0]  SUB   = bip_pkg::OP_SUB;
    localparam logic [4:0]  SUBI  = bip_pkg::OP_SUBI;
    localparam logic [15:0] HLT_W = {bip_pkg::OP_HLT, 11'h000};

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_prog_we;
    logic [NB_PC-1:0]      i_prog_addr;
    logic [15:0]           i_prog_data;
    logic                  i_req;
    logic [NB_OPERAND-1:0] i_rd_addr;
    logic                  o_ack;
    logic [NB_DATA-1:0]    o_acc;
    logic [NB_DATA-1:0]    o_rd_data;

    // Test table
    string       test_name [N_TESTS];
    logic [15:0] prog      [N_TESTS][PROG_WORDS];
    logic [10:0] rd_addr   [N_TESTS];
    logic [15:0] exp_acc   [N_TESTS];
    logic [15:0] exp_mem   [N_TESTS];
    int          hold      [N_TESTS];

    // Reference model state, persists across runs like the DUT
    logic [15:0] model_acc;
    logic [15:0] model_mem [2**NB_OPERAND];
    logic [10:0] stored [$];
    logic [15:0] lfsr;

    bip_top #(
        .NB_DATA    (NB_DATA),
        .NB_OPERAND (NB_OPERAND),
        .NB_PC      (NB_PC)
    ) i_bip_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .i_req       (i_req),
        .o_ack       (o_ack),
        .i_rd_addr   (i_rd_addr),
        .o_acc       (o_acc),
        .o_rd_data   (o_rd_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1, one bit per call
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    // Opcode in the upper five bits
    function automatic logic [15:0] enc(input logic [4:0] op, input logic [10:0] opd);
        return {op, opd};
    endfunction

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic set_entry(input int idx, input string name, input logic [10:0] addr,
                             input logic [15:0] acc, input logic [15:0] mem, input int h);
        test_name[idx] = name;
        rd_addr[idx]   = addr;
        exp_acc[idx]   = acc;
        exp_mem[idx]   = mem;
        hold[idx]      = h;
    endtask

    //////////////////////////////////////////////////
    // Program table
    //////////////////////////////////////////////////

    task automatic build_table();
        logic [15:0] rnd;
        logic [15:0] sel;
        // Negative immediates -5 and -300
        prog[0] = '{enc(LDI, 11'd100), enc(ADDI, 11'd23), enc(SUBI, 11'h7fb),
                    enc(ADDI, 11'h6d4), enc(STO, 11'h010), HLT_W, HLT_W, HLT_W,
                    HLT_W, HLT_W, HLT_W, HLT_W};
        set_entry(0, "imm_arith", 11'h010, 16'hff54, 16'hff54, 0);
        prog[1] = '{enc(LDI, 11'h155), enc(STO, 11'h020), enc(LDI, 11'h7ff),
                    enc(STO, 11'h021), enc(LDI, 11'h400), enc(STO, 11'h7ff),
                    enc(LDI, 11'h000), enc(LD, 11'h020), HLT_W, HLT_W, HLT_W, HLT_W};
        set_entry(1, "store_load", 11'h7ff, 16'h0155, 16'hfc00, 0);
        // Doubling from -1024 down to 0xc000
        prog[2] = '{enc(LDI, 11'h400), enc(STO, 11'h040), enc(ADD, 11'h040),
                    enc(STO, 11'h040), enc(ADD, 11'h040), enc(STO, 11'h040),
                    enc(ADD, 11'h040), enc(STO, 11'h040), enc(ADD, 11'h040),
                    enc(STO, 11'h040), HLT_W, HLT_W};
        set_entry(2, "mem_setup", 11'h040, 16'hc000, 16'hc000, 0);
        // 0x7fff + 1 wraps to 0x8000
        prog[3] = '{enc(LD, 11'h040), enc(ADD, 11'h040), enc(SUBI, 11'h001),
                    enc(STO, 11'h041), enc(LDI, 11'h001), enc(ADD, 11'h041),
                    enc(STO, 11'h042), enc(SUB, 11'h040), enc(ADD, 11'h041),
                    HLT_W, HLT_W, HLT_W};
        set_entry(3, "mem_wrap", 11'h042, 16'h3fff, 16'h8000, 0);
        // Accumulator already differs from the stored word
        prog[4] = '{enc(LDI, 11'h123), enc(STO, 11'h050), enc(ADDI, 11'h002),
                    enc(5'd9, 11'h050), enc(5'd31, 11'h7ff), enc(5'd15, 11'h050),
                    HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W};
        set_entry(4, "undefined_ops", 11'h050, 16'h0125, 16'h0123, 0);
        rnd = take_bits(4);
        prog[5] = '{enc(LDI, 11'h2aa), enc(SUBI, 11'h00f), enc(STO, 11'h060),
                    HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W};
        set_entry(5, "backpressure", 11'h060, 16'h029b, 16'h029b, 4 + int'(rnd[3:0]));
        // Correct only when fetch restarts at address 0
        prog[6] = '{enc(LDI, 11'h011), enc(STO, 11'h061), HLT_W, HLT_W, HLT_W,
                    HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W, HLT_W};
        set_entry(6, "rerun", 11'h061, 16'h0011, 16'h0011, 0);
        // Random bodies, expected values come from the model at run time
        for (int i = N_FIXED; i < N_TESTS; i++) begin
            rnd = take_bits(11);
            prog[i][0] = enc(LDI, rnd[10:0]);
            for (int w = 1; w < PROG_WORDS - 2; w++) begin
                sel = take_bits(2);
                case (sel[1:0])
                    2'd1: begin
                        rnd = take_bits(11);
                        prog[i][w] = enc(SUBI, rnd[10:0]);
                    end
                    2'd2: begin
                        rnd = take_bits(3);
                        prog[i][w] = enc(STO, {8'h20, rnd[2:0]});
                    end
                    default: begin
                        rnd = take_bits(11);
                        prog[i][w] = enc(ADDI, rnd[10:0]);
                    end
                endcase
            end
            set_entry(i, $sformatf("random_%0d", i - N_FIXED), {7'h18, 4'(i)}, '0, '0, 0);
            prog[i][PROG_WORDS-2] = enc(STO, rd_addr[i]);
            prog[i][PROG_WORDS-1] = HLT_W;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference interpreter
    //////////////////////////////////////////////////

    task automatic interpret_program(input int idx);
        logic [15:0] word;
        logic [15:0] imm;
        logic [10:0] opd;
        bit          halted;
        halted = 1'b0;
        stored.delete();
        for (int w = 0; w < PROG_WORDS && !halted; w++) begin
            word = prog[idx][w];
            opd  = word[10:0];
            // Operand sign bit fills the top five bits
            imm  = {{5{opd[10]}}, opd};
            case (word[15:11])
                bip_pkg::OP_HLT: halted = 1'b1;
                STO: begin
                    model_mem[opd] = model_acc;
                    stored.push_back(opd);
                end
                LD:      model_acc = model_mem[opd];
                LDI:     model_acc = imm;
                ADD:     model_acc = model_acc + model_mem[opd];
                ADDI:    model_acc = model_acc + imm;
                SUB:     model_acc = model_acc - model_mem[opd];
                SUBI:    model_acc = model_acc - imm;
                // Undefined codes change nothing
                default: ;
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // Host sequences
    //////////////////////////////////////////////////

    task automatic load_program(input int idx);
        for (int w = 0; w < PROG_WORDS; w++) begin
            @(posedge i_clk);
            i_prog_we   <= 1'b1;
            i_prog_addr <= NB_PC'(w);
            i_prog_data <= prog[idx][w];
        end
        @(posedge i_clk);
        i_prog_we <= 1'b0;
    endtask

    task automatic run_entry(input int idx);
        @(posedge i_clk);
        i_rd_addr <= rd_addr[idx];
        i_req     <= 1'b1;
        // Run length follows the program
        @(negedge i_clk);
        while (!o_ack) @(negedge i_clk);
        check_value({test_name[idx], " acc"}, exp_acc[idx], o_acc);
        check_value({test_name[idx], " mem"}, exp_mem[idx], o_rd_data);
        // Request held, results frozen
        repeat (hold[idx]) begin
            @(negedge i_clk);
            check_value({test_name[idx], " ack held"}, 16'd1, 16'(o_ack));
            check_value({test_name[idx], " acc held"}, exp_acc[idx], o_acc);
        end
        @(posedge i_clk);
        i_req <= 1'b0;
        @(negedge i_clk);
        while (o_ack) @(negedge i_clk);
        // Every word the run stored
        foreach (stored[k]) begin
            @(posedge i_clk);
            i_rd_addr <= stored[k];
            @(negedge i_clk);
            check_value({test_name[idx], " store"}, model_mem[stored[k]], o_rd_data);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        i_rst       <= 1'b0;
        i_prog_we   <= 1'b0;
        i_prog_addr <= '0;
        i_prog_data <= '0;
        i_req       <= 1'b0;
        i_rd_addr   <= '0;
        lfsr        = 16'd54019;
        model_acc   = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b1;
        build_table();
        for (int i = 0; i < N_TESTS; i++) begin
            load_program(i);
            interpret_program(i);
            if (i >= N_FIXED) begin
                exp_acc[i] = model_acc;
                exp_mem[i] = model_mem[rd_addr[i]];
            end
            run_entry(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge i_clk);
        $display("Timeout: the DUT never completed its run handshake");
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

// File: sim.f
hdl/bip_pkg.sv
hdl/bip_datapath.sv
hdl/bip_control.sv
hdl/bip_program_mem.sv
hdl/bip_data_mem.sv
hdl/bip_top.sv
verif/bip_chk.sv
verif/bip_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sim.f --top-module bip_tb -o bip_sim

# Verdict taken from the simulation output
out=$(./obj_dir/bip_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Simulation failed"
exit 1
